// ==== src/vector_mem_pkg.sv ====
// Shared address types, loader indices, load offsets and E-disk bits for the memory subsystem
`default_nettype none

package vector_mem_pkg;

    // ========================================
    // Widths and types
    // ========================================
    localparam int MEM_AW = 19;

    typedef logic [15:0]       cpu_addr_t;
    // Page number in bits 18:16, CPU address below
    typedef logic [MEM_AW-1:0] mem_addr_t;
    typedef logic [23:0]       dl_addr_t;
    typedef logic [7:0]        byte_t;
    typedef logic [2:0]        page_t;

    // ========================================
    // Loader indices and offsets
    // ========================================
    localparam byte_t IDX_ROM = 8'h01;
    localparam byte_t IDX_COM = 8'h41;
    localparam byte_t IDX_C00 = 8'h81;
    localparam byte_t IDX_EDD = 8'hC1;

    // ROM and COM images start above the zero page
    localparam dl_addr_t OFS_PROG = 24'h00_0100;
    // EDD images go to the first E-disk page
    localparam dl_addr_t OFS_EDD  = 24'h01_0000;

    // Zero-fill stops here, after wrapping in the low 64 KB
    localparam cpu_addr_t FILL_END = 16'h00FF;
    localparam cpu_addr_t LOW_MASK = 16'hFFFF;

    // ========================================
    // E-disk register bit positions
    // ========================================
    localparam int ED_WIN_HI   = 7;
    localparam int ED_WIN_LO   = 6;
    localparam int ED_RAM_EN   = 5;
    localparam int ED_STACK_EN = 4;
    // Bits 3:2 give the stack page, bits 1:0 the window page

endpackage

`default_nettype wire

// ==== src/mem_port_if.sv ====
// One RAM access port; a master drives address, data and write enable, the RAM returns read data
`timescale 1ns/1ps
`default_nettype none

interface mem_port_if import vector_mem_pkg::*; ();

    mem_addr_t addr;
    byte_t     wdata;
    logic      we;
    byte_t     rdata;

    // Side that issues accesses
    modport master (
        output addr,
        output wdata,
        output we,
        input  rdata
    );

    // Memory side
    modport ram (
        input  addr,
        input  wdata,
        input  we,
        output rdata
    );

endinterface

`default_nettype wire

// ==== src/load_writer.sv ====
// Download writer: maps loader bytes into RAM by file index and zero-fills after a ROM file load
`timescale 1ns/1ps
`default_nettype none

module load_writer import vector_mem_pkg::*; #(
    parameter int ERASE_DIV = 16
) (
    input  wire logic     clk_sys,
    input  wire logic     reset,
    input  wire logic     dl_active_i,
    input  wire byte_t    dl_index_i,
    input  wire dl_addr_t dl_addr_i,
    input  wire byte_t    dl_data_i,
    input  wire logic     dl_wr_i,
    output logic          erasing_o,
    mem_port_if.master    load_port
);

    localparam int DIV_W = $clog2(ERASE_DIV);
    localparam logic [DIV_W-1:0] DIV_LAST = DIV_W'(ERASE_DIV - 1);

    dl_addr_t         map_addr;
    logic             map_valid;
    logic             dl_write;
    logic             active_q;
    logic             rom_file_q;
    logic             trigger_q;
    logic             erasing_q;
    logic [DIV_W-1:0] div_q;
    logic             fill_step;
    logic             fill_done;
    mem_addr_t        fill_next;
    cpu_addr_t        fill_ptr;
    mem_addr_t        wr_addr_q;
    byte_t            wr_data_q;
    logic             wr_en_q;

    // ========================================
    // Download address map
    // ========================================
    always_comb begin
        map_valid = 1'b1;
        map_addr  = dl_addr_i;
        case (dl_index_i)
            IDX_ROM, IDX_COM: map_addr = dl_addr_i + OFS_PROG;
            IDX_C00:          map_addr = dl_addr_i;
            IDX_EDD:          map_addr = OFS_EDD + dl_addr_t'(dl_addr_i[15:0]);
            default:          map_valid = 1'b0;
        endcase
    end

    assign dl_write = dl_active_i & dl_wr_i & map_valid;

    // Fill pointer walks up and wraps inside page 0
    assign fill_next = (mem_addr_t'(fill_ptr) + mem_addr_t'(1)) & mem_addr_t'(LOW_MASK);
    assign fill_step = erasing_q & (div_q == DIV_LAST);
    assign fill_done = (fill_ptr == FILL_END);

    // ========================================
    // Control: file end detect and fill pacing
    // ========================================
    always_ff @(posedge clk_sys) begin
        if (reset) begin
            active_q   <= 1'b0;
            rom_file_q <= 1'b0;
            trigger_q  <= 1'b0;
            erasing_q  <= 1'b0;
            div_q      <= '0;
            wr_en_q    <= 1'b0;
        end else begin
            active_q <= dl_active_i;
            wr_en_q  <= 1'b0;
            if (dl_active_i) begin
                // A running fill is abandoned once a new file starts
                rom_file_q <= (dl_index_i == IDX_ROM);
                trigger_q  <= 1'b0;
                erasing_q  <= 1'b0;
                wr_en_q    <= dl_write;
            end else if (active_q) begin
                trigger_q <= rom_file_q;
            end else if (trigger_q) begin
                trigger_q <= 1'b0;
                erasing_q <= 1'b1;
                div_q     <= '0;
            end else if (erasing_q) begin
                if (fill_step) begin
                    div_q <= '0;
                    if (fill_done) begin
                        erasing_q <= 1'b0;
                    end else begin
                        wr_en_q <= 1'b1;
                    end
                end else begin
                    div_q <= div_q + 1'b1;
                end
            end
        end
    end

    // Write payload; fill_ptr also holds the last loaded address
    always_ff @(posedge clk_sys) begin
        if (dl_write) begin
            wr_addr_q <= map_addr[MEM_AW-1:0];
            wr_data_q <= dl_data_i;
            fill_ptr  <= map_addr[15:0];
        end else if (!dl_active_i && fill_step && !fill_done) begin
            wr_addr_q <= fill_next;
            wr_data_q <= '0;
            fill_ptr  <= fill_next[15:0];
        end
    end

    assign load_port.addr  = wr_addr_q;
    assign load_port.wdata = wr_data_q;
    assign load_port.we    = wr_en_q;
    assign erasing_o       = erasing_q;

endmodule

`default_nettype wire

// ==== src/mem_store.sv ====
// Dual-port synchronous byte RAM holding page 0 and the four E-disk pages
`timescale 1ns/1ps
`default_nettype none

module mem_store import vector_mem_pkg::*; (
    input  wire logic clk_sys,
    mem_port_if.ram   load_port,
    mem_port_if.ram   cpu_port_bus
);

    localparam int DEPTH = 2 ** MEM_AW;

    byte_t mem [DEPTH];

    // ========================================
    // Writes
    // ========================================
    // Loader write comes last so it wins on an address clash
    always_ff @(posedge clk_sys) begin
        if (cpu_port_bus.we) begin
            mem[cpu_port_bus.addr] <= cpu_port_bus.wdata;
        end
        if (load_port.we) begin
            mem[load_port.addr] <= load_port.wdata;
        end
    end

    // ========================================
    // Registered reads
    // ========================================
    // One cycle from address to data, a new read every cycle
    always_ff @(posedge clk_sys) begin
        cpu_port_bus.rdata <= mem[cpu_port_bus.addr];
    end

    // Loader port only writes
    assign load_port.rdata = '0;

endmodule

`default_nettype wire

// ==== src/cpu_port.sv ====
// CPU side of the RAM: E-disk paging register, paged address forming and read data return
`timescale 1ns/1ps
`default_nettype none

module cpu_port import vector_mem_pkg::*; (
    input  wire logic      clk_sys,
    input  wire logic      reset,
    input  wire cpu_addr_t cpu_addr_i,
    input  wire byte_t     cpu_data_i,
    input  wire logic      cpu_rd_i,
    input  wire logic      cpu_wr_i,
    input  wire logic      cpu_stack_i,
    input  wire logic      edsk_wr_i,
    output byte_t          cpu_data_o,
    mem_port_if.master     cpu_port_bus
);

    byte_t ed_reg;
    logic  edsk_q;
    logic  access;
    logic  win_mid;
    logic  win_hi;
    logic  win_lo;
    logic  win_hit;
    page_t page;

    // ========================================
    // E-disk register
    // ========================================
    // Port write is a level, capture once on its rising edge
    always_ff @(posedge clk_sys) begin
        if (reset) begin
            edsk_q <= 1'b0;
            ed_reg <= '0;
        end else begin
            edsk_q <= edsk_wr_i;
            if (edsk_wr_i && !edsk_q) begin
                ed_reg <= cpu_data_i;
            end
        end
    end

    // ========================================
    // Window decode and page select
    // ========================================
    // 0xA000-0xDFFF always, 0xE000 and 0x8000 blocks when enabled
    assign win_mid = cpu_addr_i[14] ^ cpu_addr_i[13];
    assign win_hi  = ed_reg[ED_WIN_HI] & cpu_addr_i[14] & cpu_addr_i[13];
    assign win_lo  = ed_reg[ED_WIN_LO] & ~cpu_addr_i[14] & ~cpu_addr_i[13];
    assign win_hit = cpu_addr_i[15] & (win_mid | win_hi | win_lo);

    assign access = cpu_rd_i | cpu_wr_i;

    always_comb begin
        page = '0;
        if (access) begin
            // Stack redirect takes priority over the window
            if (cpu_stack_i && ed_reg[ED_STACK_EN]) begin
                page = page_t'(ed_reg[3:2]) + page_t'(1);
            end else if (win_hit && ed_reg[ED_RAM_EN]) begin
                page = page_t'(ed_reg[1:0]) + page_t'(1);
            end
        end
    end

    // ========================================
    // RAM port
    // ========================================
    assign cpu_port_bus.addr  = {page, cpu_addr_i};
    assign cpu_port_bus.wdata = cpu_data_i;
    assign cpu_port_bus.we    = cpu_wr_i;

    // RAM read register already gives the one-cycle latency
    assign cpu_data_o = cpu_port_bus.rdata;

endmodule

`default_nettype wire

// ==== src/vector_mem_top.sv ====
// Top level of the memory subsystem; connects loader writer, RAM and paged CPU port
`timescale 1ns/1ps
`default_nettype none

module vector_mem_top import vector_mem_pkg::*; #(
    parameter int ERASE_DIV = 16
) (
    input  wire logic      clk_sys,
    input  wire logic      reset,

    // Loader side
    input  wire logic      dl_active_i,
    input  wire byte_t     dl_index_i,
    input  wire dl_addr_t  dl_addr_i,
    input  wire byte_t     dl_data_i,
    input  wire logic      dl_wr_i,

    // CPU side
    input  wire cpu_addr_t cpu_addr_i,
    input  wire byte_t     cpu_data_i,
    input  wire logic      cpu_rd_i,
    input  wire logic      cpu_wr_i,
    input  wire logic      cpu_stack_i,
    input  wire logic      edsk_wr_i,

    output wire byte_t     cpu_data_o,
    output wire logic      erasing_o
);

    // ========================================
    // RAM ports
    // ========================================
    mem_port_if load_port ();
    mem_port_if cpu_port_bus ();

    // Download and zero-fill writer
    load_writer #(
        .ERASE_DIV (ERASE_DIV)
    ) u_load_writer (
        .clk_sys     (clk_sys),
        .reset       (reset),
        .dl_active_i (dl_active_i),
        .dl_index_i  (dl_index_i),
        .dl_addr_i   (dl_addr_i),
        .dl_data_i   (dl_data_i),
        .dl_wr_i     (dl_wr_i),
        .erasing_o   (erasing_o),
        .load_port   (load_port)
    );

    mem_store u_mem_store (
        .clk_sys      (clk_sys),
        .load_port    (load_port),
        .cpu_port_bus (cpu_port_bus)
    );

    // Paged CPU access
    cpu_port u_cpu_port (
        .clk_sys      (clk_sys),
        .reset        (reset),
        .cpu_addr_i   (cpu_addr_i),
        .cpu_data_i   (cpu_data_i),
        .cpu_rd_i     (cpu_rd_i),
        .cpu_wr_i     (cpu_wr_i),
        .cpu_stack_i  (cpu_stack_i),
        .edsk_wr_i    (edsk_wr_i),
        .cpu_data_o   (cpu_data_o),
        .cpu_port_bus (cpu_port_bus)
    );

endmodule

`default_nettype wire

// ==== tb/mem_checker.sv ====
// Testbench checker; mirrors every RAM write into a model and compares each CPU read a cycle later
`timescale 1ns/1ps
`default_nettype none

module mem_checker import vector_mem_pkg::*; (
    input wire logic      clk_sys,
    input wire logic      reset,
    input wire logic      dl_active_i,
    input wire byte_t     dl_index_i,
    input wire dl_addr_t  dl_addr_i,
    input wire byte_t     dl_data_i,
    input wire logic      dl_wr_i,
    input wire cpu_addr_t cpu_addr_i,
    input wire byte_t     cpu_data_i,
    input wire logic      cpu_rd_i,
    input wire logic      cpu_wr_i,
    input wire logic      cpu_stack_i,
    input wire logic      edsk_wr_i,
    input wire byte_t     cpu_data_o,
    input wire logic      erasing_o
);

    // X marks a byte that was never written
    byte_t     model [2**MEM_AW];
    string     test_name = "none";
    int        error_count = 0;
    int        check_count = 0;
    byte_t     ed_model;
    logic      edsk_q;
    logic      erase_q;
    logic      rd_pend;
    byte_t     rd_exp;
    mem_addr_t rd_addr;
    mem_addr_t wr_addr;
    logic      load_ok;
    cpu_addr_t last_low;

    // ========================================
    // Reference address rules
    // ========================================
    function automatic mem_addr_t ref_cpu_addr(input cpu_addr_t a, input logic stack,
                                               input byte_t ed);
        logic  hit;
        page_t pg;
        hit = a[15] && ((a[14] != a[13]) || (a[14] && a[13] && ed[7])
                        || (!a[14] && !a[13] && ed[6]));
        pg = 3'd0;
        if (stack && ed[4]) begin
            pg = {1'b0, ed[3:2]} + 3'd1;
        end else if (hit && ed[5]) begin
            pg = {1'b0, ed[1:0]} + 3'd1;
        end
        return {pg, a};
    endfunction

    function automatic logic ref_load_addr(input byte_t idx, input dl_addr_t a,
                                           output mem_addr_t m);
        dl_addr_t full;
        ref_load_addr = 1'b1;
        full = a;
        if (idx == IDX_ROM || idx == IDX_COM) begin
            full = a + 24'h000100;
        end else if (idx == IDX_EDD) begin
            full = 24'h010000 + {8'h00, a[15:0]};
        end else if (idx != IDX_C00) begin
            ref_load_addr = 1'b0;
        end
        m = full[MEM_AW-1:0];
    endfunction

    // Zeros from the byte after the image, wrapping in page 0, through 0x00FF
    task automatic apply_fill();
        cpu_addr_t p;
        p = last_low;
        while (p != 16'h00FF) begin
            p = p + 16'd1;
            model[{3'b000, p}] = 8'h00;
        end
    endtask

    task automatic report_failure(input string msg);
        error_count++;
        $display("Error in test %s: %s", test_name, msg);
    endtask

    task automatic report_timeout();
        error_count++;
        if (erasing_o) begin
            $display("Timeout in test %s: erasing_o never fell, zero-fill did not end",
                     test_name);
        end else begin
            $display("Timeout in test %s: test sequence did not finish in time", test_name);
        end
    endtask

    // ========================================
    // Monitor and compare
    // ========================================
    always @(posedge clk_sys) begin
        if (reset) begin
            ed_model = 8'h00;
            edsk_q   = 1'b0;
            erase_q  = 1'b0;
            rd_pend  = 1'b0;
        end else begin
            if (rd_pend && !$isunknown(rd_exp)) begin
                check_count++;
                if (cpu_data_o !== rd_exp) begin
                    error_count++;
                    $display("Mismatch in %s at %05h: expected %02h, actual %02h",
                             test_name, rd_addr, rd_exp, cpu_data_o);
                end
            end
            // Read sees memory before this cycle's writes
            rd_pend = cpu_rd_i;
            rd_addr = ref_cpu_addr(cpu_addr_i, cpu_stack_i, ed_model);
            rd_exp  = model[rd_addr];
            if (cpu_wr_i) begin
                model[rd_addr] = cpu_data_i;
            end
            load_ok = ref_load_addr(dl_index_i, dl_addr_i, wr_addr);
            if (dl_active_i && dl_wr_i && load_ok) begin
                model[wr_addr] = dl_data_i;
                last_low       = wr_addr[15:0];
            end
            if (edsk_wr_i && !edsk_q) begin
                ed_model = cpu_data_i;
            end
            edsk_q = edsk_wr_i;
            // A fall while a download runs is a cancel, not a finished fill
            if (erase_q && !erasing_o && !dl_active_i) begin
                apply_fill();
            end
            erase_q = erasing_o;
        end
    end

endmodule

`default_nettype wire

// ==== tb/tb_vector_mem.sv ====
// Testbench top; runs downloads, zero-fill, E-disk paging and CPU access tests on the memory top
`timescale 1ns/1ps
`default_nettype none

module tb_vector_mem import vector_mem_pkg::*; ();

    localparam int ERASE_DIV = 4;
    localparam int ROM_LEN   = 64;
    localparam int COM_LEN   = 32;
    localparam int C00_LEN   = 32;
    localparam int ODD_LEN   = 16;
    localparam int EDD_LEN   = 48;
    localparam int STK_LEN   = 16;
    localparam int RND_LEN   = 64;
    // Fill steps plus one full page read, a few cycles per byte elsewhere
    localparam int WATCHDOG_CYCLES = 4 * (2 * ROM_LEN + COM_LEN + C00_LEN + ODD_LEN
                                     + 3 * EDD_LEN + 4 * STK_LEN + 2 * RND_LEN)
                                     + 65536 * (ERASE_DIV + 1) + 5000;

    logic      clk_sys = 1'b0;
    logic      reset;
    logic      dl_active_i;
    byte_t     dl_index_i;
    dl_addr_t  dl_addr_i;
    byte_t     dl_data_i;
    logic      dl_wr_i;
    cpu_addr_t cpu_addr_i;
    byte_t     cpu_data_i;
    logic      cpu_rd_i;
    logic      cpu_wr_i;
    logic      cpu_stack_i;
    logic      edsk_wr_i;
    byte_t     cpu_data_o;
    logic      erasing_o;
    integer    seed = 21854;
    int        err_start;
    int        test_count = 0;

    always #4 clk_sys = ~clk_sys;

    vector_mem_top #(
        .ERASE_DIV (ERASE_DIV)
    ) u_vector_mem_top (
        .clk_sys (clk_sys), .reset (reset),
        .dl_active_i (dl_active_i), .dl_index_i (dl_index_i), .dl_addr_i (dl_addr_i),
        .dl_data_i (dl_data_i), .dl_wr_i (dl_wr_i),
        .cpu_addr_i (cpu_addr_i), .cpu_data_i (cpu_data_i), .cpu_rd_i (cpu_rd_i),
        .cpu_wr_i (cpu_wr_i), .cpu_stack_i (cpu_stack_i), .edsk_wr_i (edsk_wr_i),
        .cpu_data_o (cpu_data_o), .erasing_o (erasing_o)
    );

    mem_checker u_checker (
        .clk_sys (clk_sys), .reset (reset),
        .dl_active_i (dl_active_i), .dl_index_i (dl_index_i), .dl_addr_i (dl_addr_i),
        .dl_data_i (dl_data_i), .dl_wr_i (dl_wr_i),
        .cpu_addr_i (cpu_addr_i), .cpu_data_i (cpu_data_i), .cpu_rd_i (cpu_rd_i),
        .cpu_wr_i (cpu_wr_i), .cpu_stack_i (cpu_stack_i), .edsk_wr_i (edsk_wr_i),
        .cpu_data_o (cpu_data_o), .erasing_o (erasing_o)
    );

    // ========================================
    // Stimulus tasks
    // ========================================
    task automatic download(input byte_t idx, input dl_addr_t base, input int len);
        @(posedge clk_sys);
        dl_active_i <= 1'b1;
        dl_index_i  <= idx;
        for (int i = 0; i < len; i++) begin
            @(posedge clk_sys);
            dl_addr_i <= base + 24'(i);
            dl_data_i <= 8'($random(seed));
            dl_wr_i   <= 1'b1;
            @(posedge clk_sys);
            dl_wr_i <= 1'b0;
        end
        @(posedge clk_sys);
        dl_active_i <= 1'b0;
        repeat (2) @(posedge clk_sys);
    endtask

    // Back-to-back reads or writes over an address range
    task automatic cpu_access(input cpu_addr_t base, input int len, input logic write,
                              input logic stack);
        for (int i = 0; i < len; i++) begin
            @(posedge clk_sys);
            cpu_addr_i  <= base + 16'(i);
            cpu_data_i  <= 8'($random(seed));
            cpu_rd_i    <= !write;
            cpu_wr_i    <= write;
            cpu_stack_i <= stack;
        end
        @(posedge clk_sys);
        cpu_rd_i    <= 1'b0;
        cpu_wr_i    <= 1'b0;
        cpu_stack_i <= 1'b0;
    endtask

    task automatic set_edisk(input byte_t val);
        @(posedge clk_sys);
        cpu_data_i <= val;
        edsk_wr_i  <= 1'b1;
        @(posedge clk_sys);
        edsk_wr_i <= 1'b0;
        @(posedge clk_sys);
    endtask

    task automatic random_write_read(input int len);
        cpu_addr_t addrs [RND_LEN];
        for (int i = 0; i < len; i++) begin
            addrs[i] = 16'($random(seed));
            @(posedge clk_sys);
            cpu_addr_i <= addrs[i];
            cpu_data_i <= 8'($random(seed));
            cpu_wr_i   <= 1'b1;
        end
        for (int i = 0; i < len; i++) begin
            @(posedge clk_sys);
            cpu_wr_i   <= 1'b0;
            cpu_rd_i   <= 1'b1;
            cpu_addr_i <= addrs[i];
        end
        @(posedge clk_sys);
        cpu_rd_i <= 1'b0;
    endtask

    // Rise is expected within a few cycles, the fall is bounded by the watchdog
    task automatic wait_fill();
        int n;
        n = 0;
        while (!erasing_o && n < 8) begin
            @(posedge clk_sys);
            n++;
        end
        if (!erasing_o) begin
            u_checker.report_failure("erasing_o did not rise after the ROM file ended");
        end else begin
            while (erasing_o) @(posedge clk_sys);
        end
    endtask

    task automatic start_test(input string name);
        test_count++;
        u_checker.test_name = name;
        err_start = u_checker.error_count;
    endtask

    task automatic finish_test();
        int errs;
        repeat (2) @(posedge clk_sys);
        @(negedge clk_sys);
        errs = u_checker.error_count - err_start;
        $display("Test %-10s %s, %0d errors", u_checker.test_name,
                 (errs == 0) ? "ok" : "FAILED", errs);
    endtask

    // ========================================
    // Test sequence
    // ========================================
    initial begin
        reset       = 1'b1;
        dl_active_i = 1'b0;
        dl_index_i  = 8'h00;
        dl_addr_i   = 24'h0;
        dl_data_i   = 8'h00;
        dl_wr_i     = 1'b0;
        cpu_addr_i  = 16'h0;
        cpu_data_i  = 8'h00;
        cpu_rd_i    = 1'b0;
        cpu_wr_i    = 1'b0;
        cpu_stack_i = 1'b0;
        edsk_wr_i   = 1'b0;
        repeat (5) @(posedge clk_sys);
        reset <= 1'b0;
        @(posedge clk_sys);

        start_test("rom_load");
        download(IDX_ROM, 24'h0, ROM_LEN);
        cpu_access(16'h0100, ROM_LEN, 1'b0, 1'b0);
        finish_test();

        // The COM file also cancels the fill left from the first ROM load
        start_test("com_c00");
        download(IDX_COM, 24'h0, COM_LEN);
        download(IDX_C00, 24'h0, C00_LEN);
        download(8'h02, 24'h0, ODD_LEN);
        cpu_access(16'h0000, 16'h0140, 1'b0, 1'b0);
        finish_test();

        start_test("zero_fill");
        download(IDX_ROM, 24'h0, ROM_LEN);
        wait_fill();
        cpu_access(16'h0000, 65536, 1'b0, 1'b0);
        finish_test();

        start_test("edd_window");
        cpu_access(16'hA000, EDD_LEN, 1'b1, 1'b0);
        download(IDX_EDD, 24'h00A000, EDD_LEN);
        set_edisk(8'h20);
        cpu_access(16'hA000, EDD_LEN, 1'b0, 1'b0);
        set_edisk(8'h00);
        cpu_access(16'hA000, EDD_LEN, 1'b0, 1'b0);
        finish_test();

        // Stack page bits 10 select page 3
        start_test("stack_page");
        set_edisk(8'h18);
        cpu_access(16'h7F00, STK_LEN, 1'b1, 1'b0);
        cpu_access(16'h7F00, STK_LEN, 1'b1, 1'b1);
        cpu_access(16'h7F00, STK_LEN, 1'b0, 1'b1);
        cpu_access(16'h7F00, STK_LEN, 1'b0, 1'b0);
        finish_test();

        start_test("random_rw");
        set_edisk(8'h00);
        random_write_read(RND_LEN);
        finish_test();

        $display("Tests: %0d, checks: %0d, errors: %0d", test_count,
                 u_checker.check_count, u_checker.error_count);
        if (u_checker.error_count == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

    // Watchdog
    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk_sys);
        u_checker.report_timeout();
        $display("Done: errors found");
        $finish;
    end

endmodule

`default_nettype wire

// ==== vector_mem.f ====
src/vector_mem_pkg.sv
src/mem_port_if.sv
src/load_writer.sv
src/mem_store.sv
src/cpu_port.sv
src/vector_mem_top.sv
tb/mem_checker.sv
tb/tb_vector_mem.sv

// ==== Bender.yml ====
package:
  name: vector_mem

sources:
  - src/vector_mem_pkg.sv
  - src/mem_port_if.sv
  - src/load_writer.sv
  - src/mem_store.sv
  - src/cpu_port.sv
  - src/vector_mem_top.sv
  - target: test
    files:
      - tb/mem_checker.sv
      - tb/tb_vector_mem.sv
